// ==== logic/imx_pkg.sv ====
//--------------------
// shared types, enums and register map of the sensor-link emulator
// imported by every block of the design and by the testbench
//--------------------
package imx_pkg;

	// bus and dimension widths
	typedef logic [7:0]  axi_addr_t;	// register byte address
	typedef logic [31:0] axi_data_t;	// register data
	typedef logic [1:0]  axi_resp_t;	// AXI response code
	typedef logic [11:0] dim_t;			// columns, rows or cycles
	typedef logic [15:0] frame_cnt_t;	// frames since reset

	localparam axi_resp_t RESP_OKAY = 2'b00;

	// pattern modes, REG_CTRL bits 5:4
	typedef enum logic [1:0] {
		PAT_HRAMP   = 2'd0,	// col * channels + channel
		PAT_VRAMP   = 2'd1,	// row number
		PAT_CONST   = 2'd2,	// constant register
		PAT_CHECKER = 2'd3	// 4x4 checkerboard
	} pattern_e;

	// frame_timer states
	typedef enum logic [2:0] {
		IDLE      = 3'd0,
		VBLANK    = 3'd1,
		LINE_ON   = 3'd2,
		LINE_OFF  = 3'd3,
		FRAME_END = 3'd4	// hblank after the last line
	} timer_state_e;

	// --------------------
	// register offsets
	localparam axi_addr_t REG_CTRL   = 8'h00;	// enable, blank lines, pattern
	localparam axi_addr_t REG_SIZE   = 8'h04;	// width, height
	localparam axi_addr_t REG_BLANK  = 8'h08;	// hblank, vblank
	localparam axi_addr_t REG_CONST  = 8'h0C;	// constant pixel value
	localparam axi_addr_t REG_STATUS = 8'h10;	// frame count, read only

endpackage

// ==== logic/cfg_if.sv ====
//--------------------
// configuration bundle from the register block
// to the frame timer and the pattern generator
//--------------------
`timescale 1ns/1ps

interface cfg_if;
	import imx_pkg::*;

	logic     enable;		// run frames
	logic     blank_lines;	// send lines during vblank
	pattern_e pattern;
	dim_t     width;		// active columns per line
	dim_t     height;		// lines per frame
	dim_t     hblank;		// cycles between lines
	dim_t     vblank;		// cycles between frames
	dim_t     const_val;	// value for PAT_CONST

	modport src (output enable, blank_lines, pattern, width, height, hblank, vblank,
		const_val);
	modport timer (input enable, blank_lines, width, height, hblank, vblank);
	modport pat (input pattern, const_val);

endinterface

// ==== logic/cfg_regs.sv ====
//--------------------
// AXI4-Lite register block, one transaction at a time
// drives the config bundle and reports the frame count
//--------------------
`timescale 1ns/1ps

module cfg_regs (
	input  logic                clk,
	input  logic                i_rst_n,
	input  imx_pkg::axi_addr_t  i_awaddr,
	input  logic                i_awvalid,
	output logic                o_awready,
	input  imx_pkg::axi_data_t  i_wdata,
	input  logic [3:0]          i_wstrb,
	input  logic                i_wvalid,
	output logic                o_wready,
	output imx_pkg::axi_resp_t  o_bresp,
	output logic                o_bvalid,
	input  logic                i_bready,
	input  imx_pkg::axi_addr_t  i_araddr,
	input  logic                i_arvalid,
	output logic                o_arready,
	output imx_pkg::axi_data_t  o_rdata,
	output imx_pkg::axi_resp_t  o_rresp,
	output logic                o_rvalid,
	input  logic                i_rready,
	input  imx_pkg::frame_cnt_t i_frame_cnt,
	cfg_if.src                  cfg
);
	import imx_pkg::*;

	logic      enable_q;
	logic      blank_q;
	pattern_e  pattern_q;
	dim_t      width_q;
	dim_t      height_q;
	dim_t      hblank_q;
	dim_t      vblank_q;
	dim_t      const_q;

	logic      wr_rdy;	// awready and wready together
	logic      bus_idle;
	logic      wr_go;
	logic      rd_go;
	logic      wr_hs;
	logic      rd_hs;
	axi_data_t wr_val;	// register value after byte strobes

	// current 32-bit view of a register
	function automatic axi_data_t reg_read(input axi_addr_t addr);
		axi_data_t v;
		v = '0;
		case (addr)
			REG_CTRL:   v = {26'd0, pattern_q, 2'b00, blank_q, enable_q};
			REG_SIZE:   v = {4'd0, height_q, 4'd0, width_q};
			REG_BLANK:  v = {4'd0, vblank_q, 4'd0, hblank_q};
			REG_CONST:  v = {20'd0, const_q};
			REG_STATUS: v = {16'd0, i_frame_cnt};
			default:    v = '0;	// unmapped reads as zero
		endcase
		return v;
	endfunction

	function automatic axi_data_t apply_strb(input axi_data_t old, input axi_data_t din,
		input logic [3:0] strb);
		axi_data_t v;
		for (int b = 0; b < 4; b++) begin
			v[8*b +: 8] = strb[b] ? din[8*b +: 8] : old[8*b +: 8];
		end
		return v;
	endfunction

	// --------------------
	// handshake
	assign bus_idle = !wr_rdy && !o_arready && !o_bvalid && !o_rvalid;
	assign wr_go    = bus_idle && i_awvalid && i_wvalid;
	assign rd_go    = bus_idle && i_arvalid && !wr_go;	// writes first
	assign wr_hs    = wr_rdy && i_awvalid && i_wvalid;
	assign rd_hs    = o_arready && i_arvalid;
	assign wr_val   = apply_strb(reg_read(i_awaddr), i_wdata, i_wstrb);

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_rdy    <= 1'b0;
			o_arready <= 1'b0;
			o_bvalid  <= 1'b0;
			o_rvalid  <= 1'b0;
			o_rdata   <= '0;
		end else begin
			wr_rdy    <= wr_go;	// one-cycle pulse
			o_arready <= rd_go;
			if (wr_hs)
				o_bvalid <= 1'b1;
			else if (i_bready)
				o_bvalid <= 1'b0;
			if (rd_hs) begin
				o_rvalid <= 1'b1;
				o_rdata  <= reg_read(i_araddr);
			end else if (i_rready) begin
				o_rvalid <= 1'b0;
			end
		end
	end

	// --------------------
	// register writes, status and unmapped ignored
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			enable_q  <= 1'b0;
			blank_q   <= 1'b0;
			pattern_q <= PAT_HRAMP;
			width_q   <= '0;
			height_q  <= '0;
			hblank_q  <= '0;
			vblank_q  <= '0;
			const_q   <= '0;
		end else if (wr_hs) begin
			case (i_awaddr)
				REG_CTRL: begin
					enable_q  <= wr_val[0];
					blank_q   <= wr_val[1];
					pattern_q <= pattern_e'(wr_val[5:4]);
				end
				REG_SIZE: begin
					width_q  <= wr_val[11:0];
					height_q <= wr_val[27:16];
				end
				REG_BLANK: begin
					hblank_q <= wr_val[11:0];
					vblank_q <= wr_val[27:16];
				end
				REG_CONST: const_q <= wr_val[11:0];
				default: ;
			endcase
		end
	end

	assign o_awready = wr_rdy;
	assign o_wready  = wr_rdy;
	assign o_bresp   = RESP_OKAY;	// never an error
	assign o_rresp   = RESP_OKAY;

	assign cfg.enable      = enable_q;
	assign cfg.blank_lines = blank_q;
	assign cfg.pattern     = pattern_q;
	assign cfg.width       = width_q;
	assign cfg.height      = height_q;
	assign cfg.hblank      = hblank_q;
	assign cfg.vblank      = vblank_q;
	assign cfg.const_val   = const_q;

	// write response held until the host takes it
	a_bvalid_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_bvalid && !i_bready |=> o_bvalid);

endmodule

// ==== logic/frame_timer.sv ====
//--------------------
// frame and line timing, optional blank lines in vblank
// config sampled at every frame start
//--------------------
`timescale 1ns/1ps

module frame_timer (
	input  logic                clk,
	input  logic                i_rst_n,
	cfg_if.timer                cfg,
	output logic                o_fval,
	output logic                o_lval,
	output imx_pkg::dim_t       o_col,
	output imx_pkg::dim_t       o_row,
	output imx_pkg::frame_cnt_t o_frame_cnt
);
	import imx_pkg::*;

	timer_state_e state;
	dim_t         cnt;		// down counter for hblank and vblank
	dim_t         col;		// column, or blank-line phase in vblank
	dim_t         row;
	dim_t         width_q;
	dim_t         height_q;
	dim_t         hblank_q;
	dim_t         vblank_q;
	logic         blank_q;
	logic         bl_on;	// blank line active
	logic         bl_room;	// a blank line and its gap still fit
	logic         frame_go;
	frame_cnt_t   frame_cnt;

	assign frame_go = cfg.enable && (state == IDLE || (state == VBLANK && cnt == '0));
	assign bl_room  = {1'b0, cnt} > ({1'b0, width_q} + {1'b0, hblank_q});

	// snapshot of the geometry for one frame
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			width_q  <= '0;
			height_q <= '0;
			hblank_q <= '0;
			vblank_q <= '0;
			blank_q  <= 1'b0;
		end else if (frame_go) begin
			width_q  <= cfg.width;
			height_q <= cfg.height;
			hblank_q <= cfg.hblank;
			vblank_q <= cfg.vblank;
			blank_q  <= cfg.blank_lines;
		end
	end

	// --------------------
	// main FSM
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= IDLE;
			cnt       <= '0;
			col       <= '0;
			row       <= '0;
			bl_on     <= 1'b0;
			frame_cnt <= '0;
		end else begin
			case (state)
				IDLE: if (frame_go) begin
					state <= LINE_OFF;	// leading hblank, fval up
					cnt   <= cfg.hblank - 1'b1;
					row   <= '0;
				end
				LINE_OFF: if (cnt == '0) begin
					state <= LINE_ON;
					col   <= '0;
				end else begin
					cnt <= cnt - 1'b1;
				end
				LINE_ON: if (col == width_q - 1'b1) begin
					cnt <= hblank_q - 1'b1;
					if (row == height_q - 1'b1) begin
						state <= FRAME_END;
					end else begin
						state <= LINE_OFF;
						row   <= row + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
				FRAME_END: if (cnt == '0) begin
					state     <= VBLANK;
					cnt       <= vblank_q - 1'b1;
					col       <= '0;
					frame_cnt <= frame_cnt + 1'b1;	// frame finished
				end else begin
					cnt <= cnt - 1'b1;
				end
				VBLANK: if (cnt == '0) begin
					bl_on <= 1'b0;
					col   <= '0;
					if (frame_go) begin
						state <= LINE_OFF;
						cnt   <= cfg.hblank - 1'b1;
						row   <= '0;
					end else begin
						state <= IDLE;	// disabled, stop here
					end
				end else begin
					cnt <= cnt - 1'b1;
					if (bl_on) begin
						if (col == width_q - 1'b1) begin
							bl_on <= 1'b0;
							col   <= '0;
						end else begin
							col <= col + 1'b1;
						end
					end else if (col < hblank_q - 1'b1) begin
						col <= col + 1'b1;	// gap before a blank line
					end else if (blank_q && bl_room) begin
						bl_on <= 1'b1;
						col   <= '0;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign o_fval      = (state == LINE_OFF) || (state == LINE_ON) || (state == FRAME_END);
	assign o_lval      = (state == LINE_ON) || (state == VBLANK && bl_on);
	assign o_col       = col;
	assign o_row       = row;
	assign o_frame_cnt = frame_cnt;

	// lines outside a frame only as blank lines
	a_blank_only: assert property (@(posedge clk) disable iff (!i_rst_n)
		$rose(o_lval) && !o_fval |-> blank_q && state == VBLANK);
	a_col_range: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_lval |-> col < width_q);

endmodule

// ==== logic/pattern_gen.sv ====
//--------------------
// test pattern source, one pixel word per channel
// one cycle from timing in to pixels out
//--------------------
`timescale 1ns/1ps

module pattern_gen #(
	parameter int DATA_WIDTH  = 10,
	parameter int CHANNEL_NUM = 4
) (
	input  logic                              clk,
	input  logic                              i_rst_n,
	cfg_if.pat                                cfg,
	input  logic                              i_fval,
	input  logic                              i_lval,
	input  imx_pkg::dim_t                     i_col,
	input  imx_pkg::dim_t                     i_row,
	output logic                              o_fval,
	output logic                              o_lval,
	output logic [DATA_WIDTH*CHANNEL_NUM-1:0] o_pix
);
	import imx_pkg::*;

	localparam int PIX_W = DATA_WIDTH * CHANNEL_NUM;

	logic [PIX_W-1:0] pix_d;

	always_comb begin
		logic [31:0]           ramp;
		logic [DATA_WIDTH-1:0] word;
		pix_d = '0;
		for (int c = 0; c < CHANNEL_NUM; c++) begin
			ramp = 32'(i_col) * 32'(CHANNEL_NUM) + 32'(c);	// interleaved columns
			case (cfg.pattern)
				PAT_HRAMP:   word = ramp[DATA_WIDTH-1:0];
				PAT_VRAMP:   word = i_row[DATA_WIDTH-1:0];
				PAT_CONST:   word = cfg.const_val[DATA_WIDTH-1:0];
				PAT_CHECKER: word = (i_col[2] ^ i_row[2]) ? '1 : '0;
				default:     word = '0;
			endcase
			// masked, not clipped; zero outside active video
			pix_d[c*DATA_WIDTH +: DATA_WIDTH] = (i_fval && i_lval) ? word : '0;
		end
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_fval <= 1'b0;
			o_lval <= 1'b0;
			o_pix  <= '0;
		end else begin
			o_fval <= i_fval;
			o_lval <= i_lval;
			o_pix  <= pix_d;
		end
	end

endmodule

// ==== logic/sync_formatter.sv ====
//--------------------
// inserts SAV/EAV sync codes around each line
// valid codes inside a frame, invalid ones in blanking; six cycles latency
//--------------------
`timescale 1ns/1ps

module sync_formatter #(
	parameter int DATA_WIDTH  = 10,
	parameter int CHANNEL_NUM = 4
) (
	input  logic                              clk,
	input  logic                              i_rst_n,
	input  logic                              i_fval,
	input  logic                              i_lval,
	input  logic [DATA_WIDTH*CHANNEL_NUM-1:0] i_pix,
	output logic                              o_fval,
	output logic                              o_lval,
	output logic [DATA_WIDTH*CHANNEL_NUM-1:0] o_pix
);
	localparam int PIX_W = DATA_WIDTH * CHANNEL_NUM;

	// fourth code word; first is all ones, second and third zero
	localparam logic [11:0] SAV_V  = (DATA_WIDTH == 10) ? 12'h200 : 12'h800;
	localparam logic [11:0] EAV_V  = (DATA_WIDTH == 10) ? 12'h274 : 12'h9D0;
	localparam logic [11:0] SAV_IV = (DATA_WIDTH == 10) ? 12'h2AC : 12'hAB0;
	localparam logic [11:0] EAV_IV = (DATA_WIDTH == 10) ? 12'h2D8 : 12'hB60;

	logic [8:0]            fval_sr;	// bit0 newest
	logic [8:0]            lval_sr;
	logic [PIX_W-1:0]      data_q [0:4];
	logic [PIX_W-1:0]      pix_q;
	logic [3:0]            rise;	// SAV word k+1 due
	logic [3:0]            fall;	// EAV word k+1 due
	logic [3:0]            line_edge;
	logic [11:0]           xyz;
	logic [DATA_WIDTH-1:0] code;

	assign rise      = lval_sr[3:0] & ~lval_sr[4:1];
	assign fall      = lval_sr[8:5] & ~lval_sr[7:4];
	assign line_edge = rise | fall;

	always_comb begin
		if (fall[3])
			xyz = i_fval ? EAV_V : EAV_IV;
		else
			xyz = i_fval ? SAV_V : SAV_IV;
		if (line_edge[3])
			code = xyz[DATA_WIDTH-1:0];
		else if (line_edge[0])
			code = '1;
		else
			code = '0;	// words two and three
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			fval_sr <= '0;
			lval_sr <= '0;
			pix_q   <= '0;
			for (int k = 0; k < 5; k++)
				data_q[k] <= '0;
		end else begin
			fval_sr   <= {fval_sr[7:0], i_fval};
			lval_sr   <= {lval_sr[7:0], i_lval};
			data_q[0] <= i_pix;
			for (int k = 1; k < 5; k++)
				data_q[k] <= data_q[k-1];
			pix_q <= (|line_edge) ? {CHANNEL_NUM{code}} : data_q[4];	// same code on all channels
		end
	end

	assign o_fval = fval_sr[5];
	assign o_lval = lval_sr[5];
	assign o_pix  = pix_q;

	a_width: assert property (@(posedge clk) DATA_WIDTH == 10 || DATA_WIDTH == 12);
	// upstream keeps fval steady through every code window
	a_fval_steady: assert property (@(posedge clk) disable iff (!i_rst_n)
		|line_edge |-> i_fval == fval_sr[8]);

endmodule

// ==== logic/imx_link_tx.sv ====
//--------------------
// sensor-link emulator top, AXI4-Lite setup and parallel video out
// register block feeds a timer, pattern and formatter chain
//--------------------
`timescale 1ns/1ps

module imx_link_tx #(
	parameter int DATA_WIDTH  = 10,
	parameter int CHANNEL_NUM = 4
) (
	input  logic                              clk,
	input  logic                              i_rst_n,
	input  imx_pkg::axi_addr_t                i_awaddr,
	input  logic                              i_awvalid,
	output logic                              o_awready,
	input  imx_pkg::axi_data_t                i_wdata,
	input  logic [3:0]                        i_wstrb,
	input  logic                              i_wvalid,
	output logic                              o_wready,
	output imx_pkg::axi_resp_t                o_bresp,
	output logic                              o_bvalid,
	input  logic                              i_bready,
	input  imx_pkg::axi_addr_t                i_araddr,
	input  logic                              i_arvalid,
	output logic                              o_arready,
	output imx_pkg::axi_data_t                o_rdata,
	output imx_pkg::axi_resp_t                o_rresp,
	output logic                              o_rvalid,
	input  logic                              i_rready,
	output logic                              o_fval,
	output logic                              o_lval,
	output logic [DATA_WIDTH*CHANNEL_NUM-1:0] o_pix_data
);
	import imx_pkg::*;

	cfg_if cfg ();

	logic                              tm_fval;
	logic                              tm_lval;
	dim_t                              tm_col;
	dim_t                              tm_row;
	frame_cnt_t                        frame_cnt;
	logic                              pg_fval;
	logic                              pg_lval;
	logic [DATA_WIDTH*CHANNEL_NUM-1:0] pg_pix;

	cfg_regs i_cfg_regs (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
		.i_wdata(i_wdata), .i_wstrb(i_wstrb), .i_wvalid(i_wvalid), .o_wready(o_wready),
		.o_bresp(o_bresp), .o_bvalid(o_bvalid), .i_bready(i_bready),
		.i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
		.o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid), .i_rready(i_rready),
		.i_frame_cnt(frame_cnt), .cfg(cfg.src)
	);

	frame_timer i_frame_timer (
		.clk(clk), .i_rst_n(i_rst_n), .cfg(cfg.timer),
		.o_fval(tm_fval), .o_lval(tm_lval), .o_col(tm_col), .o_row(tm_row),
		.o_frame_cnt(frame_cnt)
	);

	// 1 cycle
	pattern_gen #(.DATA_WIDTH(DATA_WIDTH), .CHANNEL_NUM(CHANNEL_NUM)) i_pattern_gen (
		.clk(clk), .i_rst_n(i_rst_n), .cfg(cfg.pat),
		.i_fval(tm_fval), .i_lval(tm_lval), .i_col(tm_col), .i_row(tm_row),
		.o_fval(pg_fval), .o_lval(pg_lval), .o_pix(pg_pix)
	);

	// 6 cycles
	sync_formatter #(.DATA_WIDTH(DATA_WIDTH), .CHANNEL_NUM(CHANNEL_NUM)) i_sync_formatter (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_fval(pg_fval), .i_lval(pg_lval), .i_pix(pg_pix),
		.o_fval(o_fval), .o_lval(o_lval), .o_pix(o_pix_data)
	);

endmodule

// ==== bench/tb_imx_link_tx.sv ====
//--------------------
// testbench for the sensor-link emulator, programs it over AXI4-Lite
// records the video bus for each run and checks it against reference models
//--------------------
`timescale 1ns/1ps

module tb_imx_link_tx;
	import imx_pkg::*;

	localparam int DATA_WIDTH  = 10;
	localparam int CHANNEL_NUM = 4;
	localparam int PIX_W       = DATA_WIDTH * CHANNEL_NUM;
	localparam int NUM_RUNS    = 5;	// four patterns, then blank lines
	localparam int RUN_FRAMES  = 2;

	logic             clk;
	logic             i_rst_n;
	axi_addr_t        i_awaddr;
	logic             i_awvalid;
	logic             o_awready;
	axi_data_t        i_wdata;
	logic [3:0]       i_wstrb;
	logic             i_wvalid;
	logic             o_wready;
	axi_resp_t        o_bresp;
	logic             o_bvalid;
	logic             i_bready;
	axi_addr_t        i_araddr;
	logic             i_arvalid;
	logic             o_arready;
	axi_data_t        o_rdata;
	axi_resp_t        o_rresp;
	logic             o_rvalid;
	logic             i_rready;
	logic             o_fval;
	logic             o_lval;
	logic [PIX_W-1:0] o_pix_data;

	// settings of each run
	dim_t     run_width  [NUM_RUNS];
	dim_t     run_height [NUM_RUNS];
	dim_t     run_hblank [NUM_RUNS];
	dim_t     run_vblank [NUM_RUNS];
	dim_t     run_const  [NUM_RUNS];
	pattern_e run_pat    [NUM_RUNS];
	logic     run_blank  [NUM_RUNS];

	string            test_name;
	logic [31:0]      lfsr;
	int               limit_cycles = 0;	// watchdog arms once set
	int               total_frames;
	logic             capture;
	logic             fv_q [$];	// recorded video bus
	logic             lv_q [$];
	logic [PIX_W-1:0] px_q [$];

	imx_link_tx #(.DATA_WIDTH(DATA_WIDTH), .CHANNEL_NUM(CHANNEL_NUM)) i_imx_link_tx (.*);

	initial clk = 1'b0;
	always #2 clk = ~clk;	// 4 ns

	// --------------------
	// failure reporting and compares
	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string what, input string exp_s, input string act_s);
		$display("FAILED %s %s: expected %s, actual %s", test_name, what, exp_s, act_s);
		stop_run("value mismatch");
	endtask

	task automatic check_pix(input string what, input logic [PIX_W-1:0] exp,
		input logic [PIX_W-1:0] act);
		if (act !== exp)
			report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
	endtask

	task automatic check_resp(input string what, input axi_resp_t exp, input axi_resp_t act);
		if (act !== exp)
			report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
	endtask

	task automatic check_data(input string what, input axi_data_t exp, input axi_data_t act);
		if (act !== exp)
			report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
	endtask

	task automatic check_count(input string what, input dim_t exp, input dim_t act);
		if (act !== exp)
			report_mismatch(what, $sformatf("%0d", exp), $sformatf("%0d", act));
	endtask

	// --------------------
	// random bits, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};	// one step per bit
		end
	endtask

	// --------------------
	// reference models
	// XYZ word built from the F, V and H flags and their parity bits
	function automatic logic [DATA_WIDTH-1:0] sync_word(input logic valid, input logic eav,
		input int idx);
		logic                  v;
		logic                  h;
		logic [DATA_WIDTH-1:0] xyz;
		v   = !valid;	// V set in blanking
		h   = eav;
		xyz = '0;
		xyz[DATA_WIDTH-1 -: 8] = {1'b1, 1'b0, v, h, v ^ h, h, v, v ^ h};	// F zero and P3 to P0
		case (idx)
			0:       return '1;	// preamble all ones
			3:       return xyz;
			default: return '0;
		endcase
	endfunction

	function automatic logic [DATA_WIDTH-1:0] pixel_ref(input pattern_e pat, input int col,
		input int row, input int ch, input dim_t cval);
		logic [31:0] v;
		logic [31:0] cb;
		logic [31:0] rb;
		cb = col;
		rb = row;
		case (pat)
			PAT_HRAMP: v = 32'(col * CHANNEL_NUM + ch);
			PAT_VRAMP: v = rb;
			PAT_CONST: v = {20'd0, cval};
			default:   v = (cb[2] ^ rb[2]) ? '1 : '0;	// 4x4 checker
		endcase
		return v[DATA_WIDTH-1:0];	// masked, not clipped
	endfunction

	function automatic int fval_len(input int k);
		return int'(run_hblank[k]) + int'(run_height[k]) * (int'(run_width[k]) +
			int'(run_hblank[k]));
	endfunction

	// --------------------
	// AXI4-Lite host
	task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input logic [3:0] strb);
		@(negedge clk);
		i_awaddr  = addr;
		i_awvalid = 1'b1;
		i_wdata   = data;
		i_wstrb   = strb;
		i_wvalid  = 1'b1;
		while (!o_awready) @(negedge clk);	// taken at the next rising edge
		if (!o_wready)
			stop_run("wready did not rise together with awready");
		@(negedge clk);
		i_awvalid = 1'b0;
		i_wvalid  = 1'b0;
		while (!o_bvalid) @(negedge clk);
		check_resp("write response", RESP_OKAY, o_bresp);
		i_bready = 1'b1;
		@(negedge clk);
		i_bready = 1'b0;
	endtask

	task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
		@(negedge clk);
		i_araddr  = addr;
		i_arvalid = 1'b1;
		while (!o_arready) @(negedge clk);
		@(negedge clk);
		i_arvalid = 1'b0;
		while (!o_rvalid) @(negedge clk);
		check_resp("read response", RESP_OKAY, o_rresp);
		data      = o_rdata;
		i_rready  = 1'b1;
		@(negedge clk);
		i_rready  = 1'b0;
	endtask

	task automatic read_expect(input string what, input axi_addr_t addr, input axi_data_t exp);
		axi_data_t rd;
		axi_read(addr, rd);
		check_data(what, exp, rd);
	endtask

	// record the bus where it is stable
	always @(negedge clk) begin
		if (capture) begin
			fv_q.push_back(o_fval);
			lv_q.push_back(o_lval);
			px_q.push_back(o_pix_data);
		end
	end

	// --------------------
	// expected bus built from line edges, then compared cycle by cycle
	task automatic check_trace(input int k);
		int               n;
		int               r;
		int               fv_start;
		int               frames;
		int               row;
		int               blank_cnt;
		logic             in_frame;
		logic [PIX_W-1:0] exp_px [];
		n = px_q.size();
		exp_px = new[n];
		for (int i = 0; i < n; i++)
			exp_px[i] = '0;	// idle bus
		r         = 0;
		fv_start  = 0;
		frames    = 0;
		row       = 0;
		blank_cnt = 0;
		if (n < 2 || fv_q[0] || lv_q[0] || fv_q[n-1] || lv_q[n-1])
			stop_run("video trace does not start and end idle");
		for (int i = 1; i < n; i++) begin
			if (fv_q[i] && !fv_q[i-1]) begin
				frames++;
				row      = 0;
				fv_start = i;
			end
			if (!fv_q[i] && fv_q[i-1]) begin
				check_count("fval length", dim_t'(fval_len(k)), dim_t'(i - fv_start));
				check_count("lines per frame", run_height[k], dim_t'(row));
			end
			if (lv_q[i] && !lv_q[i-1])
				r = i;
			if (!lv_q[i] && lv_q[i-1]) begin
				in_frame = fv_q[r];
				check_count("lval width", run_width[k], dim_t'(i - r));
				if (!in_frame && !run_blank[k])
					stop_run("lval pulse outside fval with blank lines off");
				for (int c = r; c < i; c++) begin
					for (int ch = 0; ch < CHANNEL_NUM; ch++)
						exp_px[c][ch*DATA_WIDTH +: DATA_WIDTH] = in_frame ?
							pixel_ref(run_pat[k], c - r, row, ch, run_const[k]) : '0;
				end
				for (int w = 0; w < 4; w++) begin
					if (r - 4 + w >= 0)	// SAV just before the rise
						exp_px[r-4+w] = {CHANNEL_NUM{sync_word(in_frame, 1'b0, w)}};
					if (i + w < n)	// EAV just after the fall
						exp_px[i+w] = {CHANNEL_NUM{sync_word(in_frame, 1'b1, w)}};
				end
				if (in_frame)
					row++;
				else
					blank_cnt++;
			end
		end
		check_count("frames in trace", dim_t'(RUN_FRAMES), dim_t'(frames));
		if (run_blank[k] && blank_cnt == 0)
			stop_run("no blank line seen during vertical blanking");
		for (int i = 0; i < n; i++)
			check_pix($sformatf("pixel bus at cycle %0d", i), exp_px[i], px_q[i]);
	endtask

	// one configured run of RUN_FRAMES frames
	task automatic do_run(input int k);
		axi_data_t rd;
		axi_data_t ctrl;
		test_name = $sformatf("run %0d %s", k, run_pat[k].name());
		ctrl = 32'({run_pat[k], 2'b00, run_blank[k], 1'b1});
		axi_write(REG_SIZE, {4'd0, run_height[k], 4'd0, run_width[k]}, 4'hF);
		axi_write(REG_BLANK, {4'd0, run_vblank[k], 4'd0, run_hblank[k]}, 4'hF);
		axi_write(REG_CONST, {20'd0, run_const[k]}, 4'hF);
		@(posedge clk);
		fv_q.delete();
		lv_q.delete();
		px_q.delete();
		capture = 1'b1;
		total_frames += RUN_FRAMES;
		axi_write(REG_CTRL, ctrl, 4'hF);
		rd = '0;
		while (rd[15:0] != total_frames[15:0])
			axi_read(REG_STATUS, rd);	// poll frame count
		axi_write(REG_CTRL, {ctrl[31:1], 1'b0}, 4'hF);	// stops after this vblank
		repeat (int'(run_vblank[k]) + 16) @(negedge clk);	// vblank, latency, EAV
		@(posedge clk);
		capture = 1'b0;
		check_trace(k);
		read_expect("REG_STATUS after run", REG_STATUS, axi_data_t'(total_frames));
	endtask

	// --------------------
	// main sequence
	initial begin
		logic [31:0] rv;
		axi_data_t   ctrl_v;
		axi_data_t   size_v;
		axi_data_t   blank_v;
		axi_data_t   const_v;
		i_rst_n      = 1'b0;
		i_awaddr     = '0;
		i_awvalid    = 1'b0;
		i_wdata      = '0;
		i_wstrb      = '0;
		i_wvalid     = 1'b0;
		i_bready     = 1'b0;
		i_araddr     = '0;
		i_arvalid    = 1'b0;
		i_rready     = 1'b0;
		capture      = 1'b0;
		total_frames = 0;
		lfsr         = 32'h7ea14c57;
		test_name    = "setup";

		// geometry of every run, fixed up front for the watchdog
		for (int k = 0; k < NUM_RUNS; k++) begin
			take_bits(4, rv);
			run_width[k] = dim_t'(32'd2 + rv);	// 2..17
			take_bits(3, rv);
			run_hblank[k] = dim_t'(32'd10 + rv);	// 10..17
			take_bits(2, rv);
			run_height[k] = dim_t'(32'd1 + rv);	// 1..4
			take_bits(4, rv);
			run_vblank[k] = dim_t'(32'd30 + rv);	// 30..45
			take_bits(12, rv);
			run_const[k] = dim_t'(rv);
			run_pat[k]   = pattern_e'(k % 4);
			run_blank[k] = 1'b0;
		end
		// last run leaves room for two blank lines per vblank
		run_width[NUM_RUNS-1]  = 12'd4;
		run_height[NUM_RUNS-1] = 12'd2;
		run_hblank[NUM_RUNS-1] = 12'd10;
		run_vblank[NUM_RUNS-1] = 12'd45;
		run_blank[NUM_RUNS-1]  = 1'b1;
		rv = 800;	// register test and reset
		for (int k = 0; k < NUM_RUNS; k++)
			rv += RUN_FRAMES * (fval_len(k) + int'(run_vblank[k])) + 300;
		limit_cycles = int'(rv);

		repeat (2) @(posedge clk);
		@(negedge clk);
		i_rst_n = 1'b1;

		// --------------------
		// reset state
		test_name = "reset";
		@(negedge clk);
		if (o_fval || o_lval)
			stop_run("fval or lval high after reset");
		check_pix("pixel bus", '0, o_pix_data);
		if (o_awready || o_wready || o_bvalid || o_arready || o_rvalid)
			stop_run("AXI ready or valid high after reset");

		// register readback, enable kept low
		test_name = "register readback";
		take_bits(32, ctrl_v);
		ctrl_v = ctrl_v & ~32'h1;
		axi_write(REG_CTRL, ctrl_v, 4'hF);
		take_bits(32, size_v);
		axi_write(REG_SIZE, size_v, 4'hF);
		take_bits(32, blank_v);
		axi_write(REG_BLANK, blank_v, 4'hF);
		take_bits(32, const_v);
		axi_write(REG_CONST, const_v, 4'hF);
		take_bits(32, rv);
		axi_write(REG_STATUS, rv, 4'hF);	// read only
		axi_write(8'h14, rv, 4'hF);	// unmapped
		read_expect("REG_CTRL", REG_CTRL, ctrl_v & 32'h0000_0032);
		read_expect("REG_SIZE", REG_SIZE, size_v & 32'h0FFF_0FFF);
		read_expect("REG_BLANK", REG_BLANK, blank_v & 32'h0FFF_0FFF);
		read_expect("REG_CONST", REG_CONST, const_v & 32'h0000_0FFF);
		read_expect("REG_STATUS", REG_STATUS, 32'd0);
		read_expect("unmapped 0x14", 8'h14, 32'd0);
		take_bits(32, rv);
		axi_write(REG_SIZE, rv, 4'b0001);	// low byte only
		read_expect("REG_SIZE byte strobe", REG_SIZE,
			{size_v[31:8], rv[7:0]} & 32'h0FFF_0FFF);

		for (int k = 0; k < NUM_RUNS; k++)
			do_run(k);

		$display("Simulation completed successfully");
		$finish;
	end

	// watchdog over the whole run
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		stop_run("watchdog timeout, the DUT stopped answering or sending frames");
	end

endmodule

// ==== compile.f ====
logic/imx_pkg.sv
logic/cfg_if.sv
logic/cfg_regs.sv
logic/frame_timer.sv
logic/pattern_gen.sv
logic/sync_formatter.sv
logic/imx_link_tx.sv
bench/tb_imx_link_tx.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_imx_link_tx
FILELIST   := compile.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0 -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
